//--- sources.f
hw/icache_pkg.sv
hw/icache_tag_if.sv
hw/icache_refill_if.sv
hw/icache_ctrl.sv
hw/icache_tag_store.sv
hw/icache_data_array.sv
hw/icache_top.sv
sim/icache_mem_model.sv
sim/tb_icache_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_icache_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

.PHONY: all build lint clean

all: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_icache_top.sv
`timescale 1ns/1ps

module tb_icache_top;

  // 16 beats of up to 4 cycles plus overhead, per request
  localparam int timeout_cycles = 6 * 2 * (16 * 4 + 10);
  localparam logic [31:0] pattern_key = 32'h5a5a_0000;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] preif_raddr_i = '0;
  logic        preif_raddr_valid_i = 1'b0;
  logic [31:0] if_rdata_o;
  logic        if_rdata_valid_o;
  logic [31:0] ram_raddr_o;
  logic        ram_raddr_valid_o;
  logic [7:0]  ram_rlen_o;
  logic        ram_rdata_ready_i;
  logic [31:0] ram_rdata_i;

  // expected response for the request in flight
  logic [31:0] exp_word = '0;
  logic [31:0] exp_bus_addr = '0;
  logic [7:0]  exp_rlen = '0;
  logic        exp_hit = 1'b0;
  int          exp_beats = 0;
  logic        started = 1'b0;

  // accepted beats since the request rose
  int          beat_count = 0;
  logic        fetch_valid_d = 1'b0;

  // reference copy of line contents
  logic        ref_valid [128];
  logic [18:0] ref_tag [128];

  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_bad = 0;
  int          cycle_count = 0;

  always #4 clk = ~clk;

  icache_top i_icache_top (.*);

  icache_mem_model i_mem_model (
    .clk           (clk),
    .rst           (rst),
    .raddr_i       (ram_raddr_o),
    .raddr_valid_i (ram_raddr_valid_o),
    .rlen_i        (ram_rlen_o),
    .rdata_ready_o (ram_rdata_ready_i),
    .rdata_o       (ram_rdata_i)
  );

  // beat counter, cleared when a new request starts
  always @(posedge clk) begin
    fetch_valid_d <= preif_raddr_valid_i;
    if (preif_raddr_valid_i && !fetch_valid_d) begin
      beat_count <= 0;
    end else if (ram_raddr_valid_o && ram_rdata_ready_i) begin
      beat_count <= beat_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("timeout after %0d cycles without finishing the sequence", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
    errors = errors + 1;
  endtask

  // nothing moves before the first fetch
  a_quiet: assert property (@(posedge clk) disable iff (rst)
    !started |-> (!if_rdata_valid_o && !ram_raddr_valid_o))
    else begin
      $display("%0t: output valid raised before any request", $time);
      errors = errors + 1;
    end

  a_word: assert property (@(posedge clk) disable iff (rst)
    if_rdata_valid_o |-> (if_rdata_o == exp_word))
    else report_mismatch("if_rdata_o", $sampled(if_rdata_o), $sampled(exp_word));

  // line-aligned for refills, exact for device space
  a_bus_addr: assert property (@(posedge clk) disable iff (rst)
    ram_raddr_valid_o |-> (ram_raddr_o == exp_bus_addr))
    else report_mismatch("ram_raddr_o", $sampled(ram_raddr_o), $sampled(exp_bus_addr));

  a_bus_rlen: assert property (@(posedge clk) disable iff (rst)
    ram_raddr_valid_o |-> (ram_rlen_o == exp_rlen))
    else report_mismatch("ram_rlen_o", {24'd0, $sampled(ram_rlen_o)}, {24'd0, $sampled(exp_rlen)});

  // 16 for a refill, 1 uncached, none on a hit
  a_beats: assert property (@(posedge clk) disable iff (rst)
    if_rdata_valid_o |-> (beat_count == exp_beats))
    else report_mismatch("beat_count", $sampled(beat_count), $sampled(exp_beats));

  a_hit_no_bus: assert property (@(posedge clk) disable iff (rst)
    exp_hit |-> !ram_raddr_valid_o)
    else begin
      $display("%0t: bus request raised on a fetch that should hit", $time);
      errors = errors + 1;
    end

  // capture edge is the first one that sees valid, pulse right after
  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    ($rose(preif_raddr_valid_i) && exp_hit) |=> if_rdata_valid_o)
    else begin
      $display("%0t: no read pulse one cycle after capture on a hit", $time);
      errors = errors + 1;
    end

  // one request, held until the pulse
  task automatic fetch(input logic [31:0] addr);
    logic        uncached;
    logic [6:0]  idx;
    logic [18:0] tag;
    logic        hit;
    uncached = addr[31:28] == 4'hA;
    idx      = addr[12:6];
    tag      = addr[31:13];
    hit      = !uncached && ref_valid[idx] && (ref_tag[idx] == tag);
    @(posedge clk);
    preif_raddr_i       <= addr;
    preif_raddr_valid_i <= 1'b1;
    started             <= 1'b1;
    exp_word            <= addr ^ pattern_key;
    exp_hit             <= hit;
    exp_bus_addr        <= uncached ? addr : {addr[31:6], 6'd0};
    exp_rlen            <= uncached ? 8'd0 : 8'd15;
    exp_beats           <= hit ? 0 : (uncached ? 1 : 16);
    @(posedge clk);
    while (!if_rdata_valid_o) begin
      @(posedge clk);
    end
    preif_raddr_valid_i <= 1'b0;
    // device space never lands in the array
    if (!uncached) begin
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
    end
  endtask

  task automatic open_test();
    errors_at_start = errors;
  endtask

  // one more edge so pending action blocks have run
  task automatic close_test(input string name);
    @(posedge clk);
    tests_run = tests_run + 1;
    if (errors == errors_at_start) begin
      $display("[%0d] %s: ok", tests_run, name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("[%0d] %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
  endtask

  initial begin
    for (int i = 0; i < 128; i++) begin
      ref_valid[i] = 1'b0;
      ref_tag[i]   = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    open_test();
    repeat (5) @(posedge clk);
    close_test("quiet after reset");

    open_test();
    fetch(32'h0000_0124);
    close_test("cold miss");

    // same line as the cold miss
    open_test();
    fetch(32'h0000_0138);
    close_test("hit in filled line");

    open_test();
    fetch(32'hA000_0010);
    fetch(32'hA000_0010);
    close_test("uncached twice");

    // index 0x41, tags 0 and 1
    open_test();
    fetch(32'h0000_1040);
    fetch(32'h0000_3040);
    fetch(32'h0000_1040);
    close_test("conflict eviction");

    open_test();
    fetch(32'h0000_0104);
    fetch(32'h0000_3f80);
    fetch(32'hA000_1230);
    fetch(32'h0000_3fbc);
    close_test("mixed with ready gaps");

    $display("tests run %0d, clean %0d, failing %0d, check errors %0d",
             tests_run, tests_run - tests_bad, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sim/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] raddr_i,
  input  logic        raddr_valid_i,
  input  logic [7:0]  rlen_i,
  output logic        rdata_ready_o,
  output logic [31:0] rdata_o
);

  // beat position inside the open burst
  logic [7:0] beat_q;
  logic [7:0] beat_nxt;
  // idle cycles left before the next ready
  logic [1:0] gap_q;
  logic       last_beat;

  // word contents, byte address xor a fixed key
  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  initial begin
    void'($urandom(32'h4d0c));
    rdata_ready_o = 1'b0;
    rdata_o       = '0;
  end

  // beat moves this cycle when ready is up, valid is already known high
  assign last_beat = rdata_ready_o && (beat_q == rlen_i);
  assign beat_nxt  = rdata_ready_o ? beat_q + 8'd1 : beat_q;

  always @(posedge clk) begin
    if (rst) begin
      rdata_ready_o <= 1'b0;
      rdata_o       <= '0;
      beat_q        <= '0;
      gap_q         <= '0;
    end else if (!raddr_valid_i || last_beat) begin
      // no burst open, or its final beat moves now
      rdata_ready_o <= 1'b0;
      beat_q        <= '0;
    end else begin
      beat_q  <= beat_nxt;
      rdata_o <= pattern_word(raddr_i + {22'd0, beat_nxt, 2'b00});
      if (gap_q != 2'd0) begin
        rdata_ready_o <= 1'b0;
        gap_q         <= gap_q - 2'd1;
      end else begin
        // up to 3 stall cycles after each beat
        rdata_ready_o <= 1'b1;
        gap_q         <= 2'($urandom_range(0, 3));
      end
    end
  end

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ps

module icache_top (
  input  logic                          clk,
  input  logic                          rst,
  // fetch side
  input  logic [icache_pkg::addr_w-1:0] preif_raddr_i,
  input  logic                          preif_raddr_valid_i,
  output logic [icache_pkg::addr_w-1:0] if_rdata_o,
  output logic                          if_rdata_valid_o,
  // memory read bus
  output logic [icache_pkg::addr_w-1:0] ram_raddr_o,
  output logic                          ram_raddr_valid_o,
  output logic [7:0]                    ram_rlen_o,
  input  logic                          ram_rdata_ready_i,
  input  logic [icache_pkg::addr_w-1:0] ram_rdata_i
);

  // word read from the data array
  logic [icache_pkg::addr_w-1:0] array_rdata;

  // controller to tag store
  icache_tag_if i_tag_if ();

  // controller to data array
  icache_refill_if i_refill_if ();

  // FSM, bus and output select
  icache_ctrl i_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .preif_raddr_i       (preif_raddr_i),
    .preif_raddr_valid_i (preif_raddr_valid_i),
    .array_rdata_i       (array_rdata),
    .tag_port            (i_tag_if.ctrl),
    .refill_port         (i_refill_if.ctrl),
    .if_rdata_o          (if_rdata_o),
    .if_rdata_valid_o    (if_rdata_valid_o),
    .ram_raddr_o         (ram_raddr_o),
    .ram_raddr_valid_o   (ram_raddr_valid_o),
    .ram_rlen_o          (ram_rlen_o),
    .ram_rdata_ready_i   (ram_rdata_ready_i),
    .ram_rdata_i         (ram_rdata_i)
  );

  // valid bits and tags
  icache_tag_store i_tag_store (
    .clk      (clk),
    .rst      (rst),
    .tag_port (i_tag_if.store)
  );

  // read address taken straight from the fetch port
  // so the word is ready in the lookup cycle
  icache_data_array i_data_array (
    .clk         (clk),
    .raddr_i     (preif_raddr_i),
    .refill_port (i_refill_if.array),
    .rdata_o     (array_rdata)
  );

endmodule

//--- hw/icache_data_array.sv
`timescale 1ns/1ps

module icache_data_array (
  input  logic                          clk,
  // raw fetch address, read lands one cycle later
  input  logic [icache_pkg::addr_w-1:0] raddr_i,
  icache_refill_if.array                refill_port,
  output logic [icache_pkg::addr_w-1:0] rdata_o
);

  // 128 lines x 16 words
  logic [icache_pkg::addr_w-1:0] mem [icache_pkg::num_lines << icache_pkg::word_sel_w];
  icache_pkg::icache_addr_u      raddr;
  logic [icache_pkg::index_w+icache_pkg::word_sel_w-1:0] rd_word_addr;
  logic [icache_pkg::index_w+icache_pkg::word_sel_w-1:0] wr_word_addr;

  // field view of the fetch address
  assign raddr = raddr_i;

  // index selects the line, word select the entry in it
  assign rd_word_addr = {raddr.f.index, raddr.f.word};
  assign wr_word_addr = {refill_port.beat_index, refill_port.beat_word};

  // registered read
  always_ff @(posedge clk) begin
    rdata_o <= mem[rd_word_addr];
  end

  // one beat per accepted bus transfer
  always_ff @(posedge clk) begin
    if (refill_port.beat_we) begin
      mem[wr_word_addr] <= refill_port.beat_data;
    end
  end

  // beat position must be known when a beat is written
  a_beat_word_known: assert property (@(posedge clk)
    refill_port.beat_we |-> !$isunknown(refill_port.beat_word));

endmodule

//--- hw/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store (
  input  logic        clk,
  input  logic        rst,
  icache_tag_if.store tag_port
);

  // one valid bit and one tag per line
  logic [icache_pkg::num_lines-1:0] valid_q;
  logic [icache_pkg::tag_w-1:0]     tag_mem [icache_pkg::num_lines];
  logic [icache_pkg::tag_w-1:0]     stored_tag;
  logic                             line_valid;

  // read both at the lookup index
  assign stored_tag = tag_mem[tag_port.lookup_index];
  assign line_valid = valid_q[tag_port.lookup_index];

  // valid and tag equal
  assign tag_port.hit = line_valid && (stored_tag == tag_port.lookup_tag);

  // valid bits cleared on reset, set once the line is filled
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_port.tag_we) begin
      valid_q[tag_port.lookup_index] <= 1'b1;
    end
  end

  // tag storage
  always_ff @(posedge clk) begin
    if (tag_port.tag_we) begin
      tag_mem[tag_port.lookup_index] <= tag_port.lookup_tag;
    end
  end

  // a refill only ever follows a miss on the same line
  a_no_write_on_hit: assert property (@(posedge clk) disable iff (rst)
    tag_port.tag_we |-> !tag_port.hit);

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  // fetch side
  input  logic [icache_pkg::addr_w-1:0] preif_raddr_i,
  input  logic                          preif_raddr_valid_i,
  // registered word from the data array
  input  logic [icache_pkg::addr_w-1:0] array_rdata_i,
  icache_tag_if.ctrl                    tag_port,
  icache_refill_if.ctrl                 refill_port,
  output logic [icache_pkg::addr_w-1:0] if_rdata_o,
  output logic                          if_rdata_valid_o,
  // memory read bus
  output logic [icache_pkg::addr_w-1:0] ram_raddr_o,
  output logic                          ram_raddr_valid_o,
  output logic [7:0]                    ram_rlen_o,
  input  logic                          ram_rdata_ready_i,
  input  logic [icache_pkg::addr_w-1:0] ram_rdata_i
);

  icache_pkg::icache_state_e            state_q;
  icache_pkg::icache_addr_u             req_q;
  icache_pkg::icache_addr_u             line_addr;
  // as wide as rlen, so an overrun past the last beat stays visible
  logic [7:0]                           beat_cnt_q;
  logic [icache_pkg::addr_w-1:0]        unc_data_q;
  logic                                 unc_ready_q;
  logic                                 tag_we_q;
  logic                                 req_uncached;
  logic                                 req_take;
  logic                                 beat_fire;
  logic                                 lookup_hit;

  // device region check on the held request
  assign req_uncached = req_q.flat[icache_pkg::addr_w-1 -: 4] == icache_pkg::uncached_region;

  // line-aligned refill address
  always_comb begin
    line_addr            = req_q;
    line_addr.f.word     = '0;
    line_addr.f.byte_off = '0;
  end

  // the uncached pulse cycle consumes the held request,
  // so it is not taken again in that cycle
  assign req_take = (state_q == icache_pkg::st_idle) && preif_raddr_valid_i && !unc_ready_q;

  // one beat moves per valid and ready cycle
  assign beat_fire = ram_raddr_valid_o && ram_rdata_ready_i;

  // cacheable hit, one cycle after capture
  assign lookup_hit = (state_q == icache_pkg::st_lookup) && tag_port.hit && !req_uncached;

  // tag store driven from the captured address
  assign tag_port.lookup_tag   = req_q.f.tag;
  assign tag_port.lookup_index = req_q.f.index;
  assign tag_port.tag_we       = tag_we_q;

  // every accepted refill beat goes straight into the array
  assign refill_port.beat_we    = beat_fire && (state_q == icache_pkg::st_refill);
  assign refill_port.beat_index = req_q.f.index;
  assign refill_port.beat_word  = beat_cnt_q[icache_pkg::word_sel_w-1:0];
  assign refill_port.beat_data  = ram_rdata_i;

  // request capture
  always_ff @(posedge clk) begin
    if (req_take) begin
      req_q.flat <= preif_raddr_i;
    end
  end

  // main FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q           <= icache_pkg::st_rst;
      ram_raddr_valid_o <= 1'b0;
      tag_we_q          <= 1'b0;
      unc_ready_q       <= 1'b0;
      beat_cnt_q        <= '0;
    end else begin
      // single-cycle pulses
      tag_we_q    <= 1'b0;
      unc_ready_q <= 1'b0;
      case (state_q)
        icache_pkg::st_rst: begin
          state_q <= icache_pkg::st_idle;
        end
        icache_pkg::st_idle: begin
          if (req_take) begin
            state_q <= icache_pkg::st_lookup;
          end
        end
        icache_pkg::st_lookup: begin
          if (req_uncached) begin
            // single word at the exact address
            state_q           <= icache_pkg::st_uncached;
            ram_raddr_valid_o <= 1'b1;
          end else if (!tag_port.hit) begin
            // whole line, count from word 0
            state_q           <= icache_pkg::st_refill;
            ram_raddr_valid_o <= 1'b1;
            beat_cnt_q        <= '0;
          end else begin
            state_q <= icache_pkg::st_idle;
          end
        end
        icache_pkg::st_refill: begin
          if (beat_fire) begin
            if (beat_cnt_q == icache_pkg::burst_last) begin
              // line complete, validate tag next cycle
              state_q           <= icache_pkg::st_idle;
              ram_raddr_valid_o <= 1'b0;
              tag_we_q          <= 1'b1;
            end else begin
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
        end
        icache_pkg::st_uncached: begin
          if (beat_fire) begin
            state_q           <= icache_pkg::st_idle;
            ram_raddr_valid_o <= 1'b0;
            unc_ready_q       <= 1'b1;
          end
        end
        default: begin
          state_q <= icache_pkg::st_idle;
        end
      endcase
    end
  end

  // bus address and length, steady for the whole burst
  always_ff @(posedge clk) begin
    if (state_q == icache_pkg::st_lookup) begin
      if (req_uncached) begin
        ram_raddr_o <= req_q.flat;
        ram_rlen_o  <= 8'd0;
      end else begin
        ram_raddr_o <= line_addr.flat;
        ram_rlen_o  <= icache_pkg::burst_last;
      end
    end
  end

  // uncached holding register
  always_ff @(posedge clk) begin
    if ((state_q == icache_pkg::st_uncached) && beat_fire) begin
      unc_data_q <= ram_rdata_i;
    end
  end

  // output select, holding register only in the uncached pulse
  assign if_rdata_valid_o = lookup_hit || unc_ready_q;
  assign if_rdata_o       = unc_ready_q ? unc_data_q : array_rdata_i;

  // no bus request outside refill and uncached reads
  a_no_bus_idle: assert property (@(posedge clk) disable iff (rst)
    (state_q == icache_pkg::st_idle || state_q == icache_pkg::st_lookup)
      |-> !ram_raddr_valid_o);

  // CPU sees a one-cycle pulse per request
  a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
    if_rdata_valid_o |=> !if_rdata_valid_o);

  // beat count stays inside the line
  a_beat_range: assert property (@(posedge clk) disable iff (rst)
    (state_q == icache_pkg::st_refill) |-> (beat_cnt_q <= icache_pkg::burst_last));

endmodule

//--- hw/icache_refill_if.sv
`timescale 1ns/1ps

// refill beats from controller into the data array
interface icache_refill_if;

  // high only in cycles where a beat is accepted on the bus
  logic                              beat_we;
  logic [icache_pkg::index_w-1:0]    beat_index;
  logic [icache_pkg::word_sel_w-1:0] beat_word;
  logic [icache_pkg::addr_w-1:0]     beat_data;

  modport ctrl (
    output beat_we,
    output beat_index,
    output beat_word,
    output beat_data
  );

  modport array (input beat_we, input beat_index, input beat_word, input beat_data);

endinterface

//--- hw/icache_tag_if.sv
`timescale 1ns/1ps

// lookup and tag write between controller and tag store
interface icache_tag_if;

  // line being looked up or refilled
  logic [icache_pkg::tag_w-1:0]   lookup_tag;
  logic [icache_pkg::index_w-1:0] lookup_index;
  // one-cycle pulse after the last refill beat
  logic                           tag_we;
  // combinational, valid and tag equal
  logic                           hit;

  modport ctrl (output lookup_tag, output lookup_index, output tag_we, input hit);

  modport store (input lookup_tag, input lookup_index, input tag_we, output hit);

endinterface

//--- hw/icache_pkg.sv
package icache_pkg;

  // bus address and instruction word width
  localparam int addr_w = 32;

  // address split for an 8 KB direct-mapped cache
  localparam int tag_w = 19;
  localparam int index_w = 7;
  localparam int offset_w = 6;

  // 16 words of 32 bits per 64-byte line
  localparam int word_sel_w = 4;
  localparam int num_lines = 128;

  // rlen code for a full line refill, 16 beats
  localparam logic [7:0] burst_last = 8'd15;

  // bits 31..28 of device space, never cached
  localparam logic [3:0] uncached_region = 4'hA;

  // fetch address
  // flat view goes on the memory bus, field view addresses the arrays
  typedef union packed {
    logic [addr_w-1:0] flat;
    struct packed {
      logic [tag_w-1:0]               tag;
      logic [index_w-1:0]             index;
      logic [word_sel_w-1:0]          word;
      logic [offset_w-word_sel_w-1:0] byte_off;
    } f;
  } icache_addr_u;

  // controller states
  typedef enum logic [2:0] {
    st_rst      = 3'd0,
    st_idle     = 3'd1,
    st_lookup   = 3'd2,
    st_refill   = 3'd3,
    st_uncached = 3'd4
  } icache_state_e;

endpackage
